/* logic/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    localparam int XLEN = 32; // Data and address width

    //////////////////////////////////////////////////
    // Opcodes, bits [31:26]
    //////////////////////////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'b000000; // Funct picks the op
    localparam logic [5:0] OP_ADDI  = 6'b001000; // Sign-extended imm
    localparam logic [5:0] OP_ANDI  = 6'b001100; // Zero-extended imm
    localparam logic [5:0] OP_ORI   = 6'b001101; // Zero-extended imm
    localparam logic [5:0] OP_XORI  = 6'b001110; // Zero-extended imm
    localparam logic [5:0] OP_SLTIU = 6'b001011; // Sign-extended, unsigned compare
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;

    //////////////////////////////////////////////////
    // Funct codes for R-type, bits [5:0]
    //////////////////////////////////////////////////
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_ADD  = 6'b100000; // Wraps, no trap
    localparam logic [5:0] FN_SUB  = 6'b100010; // Wraps, no trap
    localparam logic [5:0] FN_SLTU = 6'b101011;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLL  = 6'b000000; // Shift by shamt

    //////////////////////////////////////////////////
    // Instruction formats
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [5:0] opcode; // [31:26]
        logic [4:0] rs;     // [25:21]
        logic [4:0] rt;     // [20:16]
        logic [4:0] rd;     // [15:11]
        logic [4:0] shamt;  // [10:6]
        logic [5:0] funct;  // [5:0]
    } r_format_t;

    typedef struct packed {
        logic [5:0]  opcode; // Same slot as the R view
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;    // Offset or constant
    } i_format_t;

    // One word, two readings
    // Opcode decides which view holds
    typedef union packed {
        r_format_t r;
        i_format_t i;
    } instr_t;

endpackage

`default_nettype wire

/* logic/mips_alu_pkg.sv */
`default_nettype none

package mips_alu_pkg;

    localparam int ALU_OP_W = 4; // Op code width, as in the ALU table
    localparam int SHAMT_W  = 5; // Shift amount width

    //////////////////////////////////////////////////
    // ALU operations
    //////////////////////////////////////////////////
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_AND  = 4'b0000, // a & b
        ALU_OR   = 4'b0001, // a | b
        ALU_ADD  = 4'b0010, // a + b
        ALU_SLL  = 4'b0011, // b << shamt
        ALU_SUB  = 4'b0110, // a - b, also the branch compare
        ALU_SLTU = 4'b0111, // Unsigned a < b
        ALU_NOR  = 4'b1100, // ~(a | b)
        ALU_XOR  = 4'b1101, // a ^ b
        ALU_BAD  = 4'b1111  // Undecoded, all ones out
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE = 2'b00,
        BR_EQ   = 2'b01, // Taken on zero
        BR_NE   = 2'b10  // Taken on nonzero
    } branch_kind_t;

    // Decoder output
    typedef struct packed {
        alu_op_t      alu_op;
        logic         use_imm;     // Second operand from imm
        logic         zero_ext;    // Zero- instead of sign-extension
        branch_kind_t branch_kind;
        logic         illegal;     // Unknown opcode or funct
    } ex_ctrl_t;

    // Request into the stage, 128 bits
    typedef struct packed {
        mips_isa_pkg::instr_t              instr;
        logic [mips_isa_pkg::XLEN-1:0]     pc;
        logic [mips_isa_pkg::XLEN-1:0]     rs_val;
        logic [mips_isa_pkg::XLEN-1:0]     rt_val;
    } ex_req_t;

    // Registered response
    typedef struct packed {
        logic [mips_isa_pkg::XLEN-1:0] result;
        logic                          zero;
        logic                          taken;
        logic [mips_isa_pkg::XLEN-1:0] target;  // 0 for non-branches
        logic                          illegal;
    } ex_rsp_t;

endpackage

`default_nettype wire

/* logic/alu_control.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_control
(
    input  wire mips_isa_pkg::instr_t    i_instr,
    output mips_alu_pkg::ex_ctrl_t       o_ctrl
);

    //////////////////////////////////////////////////
    // Opcode first, then funct for R-type
    //////////////////////////////////////////////////
    always_comb
    begin
        // Defaults describe an illegal word
        o_ctrl.alu_op      = mips_alu_pkg::ALU_BAD;
        o_ctrl.use_imm     = 1'b0;
        o_ctrl.zero_ext    = 1'b0; // Sign unless told otherwise
        o_ctrl.branch_kind = mips_alu_pkg::BR_NONE;
        o_ctrl.illegal     = 1'b0;

        case (i_instr.i.opcode)
            mips_isa_pkg::OP_RTYPE:
            begin
                case (i_instr.r.funct) // R view of the word
                    mips_isa_pkg::FN_AND:  o_ctrl.alu_op = mips_alu_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   o_ctrl.alu_op = mips_alu_pkg::ALU_OR;
                    mips_isa_pkg::FN_ADD:  o_ctrl.alu_op = mips_alu_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUB:  o_ctrl.alu_op = mips_alu_pkg::ALU_SUB;
                    mips_isa_pkg::FN_SLTU: o_ctrl.alu_op = mips_alu_pkg::ALU_SLTU;
                    mips_isa_pkg::FN_NOR:  o_ctrl.alu_op = mips_alu_pkg::ALU_NOR;
                    mips_isa_pkg::FN_XOR:  o_ctrl.alu_op = mips_alu_pkg::ALU_XOR;
                    mips_isa_pkg::FN_SLL:  o_ctrl.alu_op = mips_alu_pkg::ALU_SLL;
                    default:               o_ctrl.illegal = 1'b1; // Unknown funct
                endcase
            end
            mips_isa_pkg::OP_ADDI:
            begin
                o_ctrl.alu_op  = mips_alu_pkg::ALU_ADD;
                o_ctrl.use_imm = 1'b1;
            end
            mips_isa_pkg::OP_ANDI:
            begin
                o_ctrl.alu_op   = mips_alu_pkg::ALU_AND;
                o_ctrl.use_imm  = 1'b1;
                o_ctrl.zero_ext = 1'b1; // Logical ops zero-extend
            end
            mips_isa_pkg::OP_ORI:
            begin
                o_ctrl.alu_op   = mips_alu_pkg::ALU_OR;
                o_ctrl.use_imm  = 1'b1;
                o_ctrl.zero_ext = 1'b1;
            end
            mips_isa_pkg::OP_XORI:
            begin
                o_ctrl.alu_op   = mips_alu_pkg::ALU_XOR;
                o_ctrl.use_imm  = 1'b1;
                o_ctrl.zero_ext = 1'b1;
            end
            mips_isa_pkg::OP_SLTIU:
            begin
                o_ctrl.alu_op  = mips_alu_pkg::ALU_SLTU; // Sign-extended, compared unsigned
                o_ctrl.use_imm = 1'b1;
            end
            mips_isa_pkg::OP_BEQ:
            begin
                o_ctrl.alu_op      = mips_alu_pkg::ALU_SUB; // rs - rt, zero on equal
                o_ctrl.branch_kind = mips_alu_pkg::BR_EQ;
            end
            mips_isa_pkg::OP_BNE:
            begin
                o_ctrl.alu_op      = mips_alu_pkg::ALU_SUB;
                o_ctrl.branch_kind = mips_alu_pkg::BR_NE;
            end
            default: o_ctrl.illegal = 1'b1; // Unknown opcode
        endcase
    end

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu
(
    input  wire [mips_isa_pkg::XLEN-1:0]      i_reg,     // rs value
    input  wire [mips_isa_pkg::XLEN-1:0]      i_operand, // rt value or extended imm
    input  wire [mips_alu_pkg::SHAMT_W-1:0]   i_shamt,
    input  wire mips_alu_pkg::alu_op_t        i_op,
    output logic [mips_isa_pkg::XLEN-1:0]     o_result,
    output logic                              o_zero
);

    logic lt_unsigned; // Compare result, one bit

    // Plain vectors compare unsigned
    assign lt_unsigned = (i_reg < i_operand);

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////
    always_comb
    begin
        case (i_op)
            mips_alu_pkg::ALU_AND:
                o_result = i_reg & i_operand;
            mips_alu_pkg::ALU_OR:
                o_result = i_reg | i_operand;
            mips_alu_pkg::ALU_ADD:
                o_result = i_reg + i_operand;  // Wraps
            mips_alu_pkg::ALU_SUB:
                o_result = i_reg - i_operand;  // Wraps
            mips_alu_pkg::ALU_SLTU:
            begin
                // Zero-filled flag
                o_result = {{(mips_isa_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            mips_alu_pkg::ALU_NOR:
                o_result = ~(i_reg | i_operand);
            mips_alu_pkg::ALU_XOR:
                o_result = i_reg ^ i_operand;
            mips_alu_pkg::ALU_SLL:
                o_result = i_operand << i_shamt; // Second operand shifted, rs unused
            default:
                o_result = '1;                 // ALU_BAD and any stray code
        endcase
    end

    // Zero flag straight off the result
    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

/* logic/branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_unit
(
    input  wire [mips_isa_pkg::XLEN-1:0]    i_pc,
    input  wire [mips_isa_pkg::XLEN-1:0]    i_offset, // Sign-extended imm, in words
    input  wire mips_alu_pkg::branch_kind_t i_kind,
    input  wire                             i_zero,   // From the rs - rt compare
    output logic                            o_taken,
    output logic [mips_isa_pkg::XLEN-1:0]   o_target
);

    logic [mips_isa_pkg::XLEN-1:0] pc_plus4;
    logic [mips_isa_pkg::XLEN-1:0] branch_addr;

    assign pc_plus4    = i_pc + mips_isa_pkg::XLEN'(4);
    assign branch_addr = pc_plus4 + (i_offset << 2); // Word offset to bytes, wraps

    //////////////////////////////////////////////////
    // Decision and target
    //////////////////////////////////////////////////
    always_comb
    begin
        case (i_kind)
            mips_alu_pkg::BR_EQ:
            begin
                o_taken  = i_zero;       // Equal operands
                o_target = branch_addr;
            end
            mips_alu_pkg::BR_NE:
            begin
                o_taken  = ~i_zero;      // Unequal operands
                o_target = branch_addr;
            end
            default:
            begin
                // Non-branch, both cleared
                o_taken  = 1'b0;
                o_target = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/mips_ex.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_ex
(
    input  wire                          i_clk,
    input  wire                          i_arst_n,
    // Request side
    input  wire mips_alu_pkg::ex_req_t   i_req,
    input  wire                          i_req_valid,
    output logic                         o_req_ready,
    // Response side
    output mips_alu_pkg::ex_rsp_t        o_rsp,
    output logic                         o_rsp_valid,
    input  wire                          i_rsp_ready
);

    mips_alu_pkg::ex_ctrl_t        ctrl;        // Decoded control
    logic [15:0]                   imm;
    logic [mips_isa_pkg::XLEN-1:0] imm_sext;
    logic [mips_isa_pkg::XLEN-1:0] imm_zext;
    logic [mips_isa_pkg::XLEN-1:0] operand_b;   // Second ALU input
    logic [mips_isa_pkg::XLEN-1:0] alu_result;
    logic                          alu_zero;
    logic                          br_taken;
    logic [mips_isa_pkg::XLEN-1:0] br_target;
    mips_alu_pkg::ex_rsp_t         rsp_d;       // Next response
    mips_alu_pkg::ex_rsp_t         rsp_q;       // Held response
    logic                          rsp_valid_q;
    logic                          accept;      // Request taken this edge

    //////////////////////////////////////////////////
    // Decode and operand select
    //////////////////////////////////////////////////
    alu_control u_alu_control
    (
        .i_instr (i_req.instr),
        .o_ctrl  (ctrl)
    );

    assign imm      = i_req.instr.i.imm; // I view of the word
    assign imm_sext = {{(mips_isa_pkg::XLEN-16){imm[15]}}, imm};
    assign imm_zext = {{(mips_isa_pkg::XLEN-16){1'b0}}, imm};

    // rt for R-type and branches
    assign operand_b = ctrl.use_imm ? (ctrl.zero_ext ? imm_zext : imm_sext)
                                    : i_req.rt_val;

    alu u_alu
    (
        .i_reg     (i_req.rs_val),
        .i_operand (operand_b),
        .i_shamt   (i_req.instr.r.shamt), // R view for sll
        .i_op      (ctrl.alu_op),
        .o_result  (alu_result),
        .o_zero    (alu_zero)
    );

    branch_unit u_branch_unit
    (
        .i_pc     (i_req.pc),
        .i_offset (imm_sext),        // Branch offsets always sign-extend
        .i_kind   (ctrl.branch_kind),
        .i_zero   (alu_zero),
        .o_taken  (br_taken),
        .o_target (br_target)
    );

    // Response assembly
    assign rsp_d.result  = alu_result;
    assign rsp_d.zero    = alu_zero;
    assign rsp_d.taken   = br_taken;
    assign rsp_d.target  = br_target;
    assign rsp_d.illegal = ctrl.illegal;

    //////////////////////////////////////////////////
    // One-entry output register
    //////////////////////////////////////////////////
    // Free slot, or the held item leaves this edge
    assign o_req_ready = ~rsp_valid_q | i_rsp_ready;
    assign accept      = i_req_valid & o_req_ready;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            rsp_valid_q <= 1'b0;
        end
        else if (accept)
        begin
            rsp_valid_q <= 1'b1; // Visible one edge after acceptance
        end
        else if (i_rsp_ready)
        begin
            rsp_valid_q <= 1'b0; // Drained, nothing new
        end
    end

    // Payload only, qualified by rsp_valid_q
    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            rsp_q <= rsp_d; // Holds under back-pressure
        end
    end

    assign o_rsp       = rsp_q;
    assign o_rsp_valid = rsp_valid_q;

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
(
    output logic o_clk,
    output logic o_arst_n
);

    localparam int PERIOD       = 40; // ns
    localparam int RESET_CYCLES = 16;
    localparam int RELEASE_DLY  = 2;  // Same offset as the stimulus

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial
    begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #RELEASE_DLY;
        o_arst_n = 1'b1; // Away from both clock edges
    end

endmodule

`default_nettype wire

/* testbench/mips_ex_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_ex_sva
(
    input wire                        i_clk,
    input wire                        i_arst_n,
    input wire                        i_req_ready,
    input wire mips_alu_pkg::ex_rsp_t i_rsp,
    input wire                        i_rsp_valid,
    input wire                        i_rsp_ready
);

    int fail_count = 0; // Failed assertions so far

    // Output register empty in reset and on the first edge after it
    a_reset_empty: assert property (@(posedge i_clk)
        (!i_arst_n || $rose(i_arst_n)) |-> !i_rsp_valid)
        else
        begin
            fail_count++;
            $error("o_rsp_valid high during or right after reset");
        end

    // Held response frozen while the consumer stalls
    a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_rsp_valid && !i_rsp_ready) |=> (i_rsp_valid && $stable(i_rsp)))
        else
        begin
            fail_count++;
            $error("Response changed or dropped under back-pressure");
        end

    a_ready_when_empty: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !i_rsp_valid |-> i_req_ready)
        else
        begin
            fail_count++;
            $error("o_req_ready low with an empty output register");
        end

endmodule

bind mips_ex mips_ex_sva sva_i
(
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_req_ready (o_req_ready),
    .i_rsp       (o_rsp),
    .i_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready)
);

`default_nettype wire

/* testbench/mips_ex_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_ex_tb;

    localparam int    DRIVE_DELAY = 2;   // ns after the rising edge
    localparam int    WAIT_LIMIT  = 200; // Cycles per wait loop
    localparam string CASE_FILE   = "testbench/mips_ex_cases.txt";

    logic                  clk;
    logic                  arst_n;
    mips_alu_pkg::ex_req_t req;
    logic                  req_valid;
    logic                  req_ready;
    mips_alu_pkg::ex_rsp_t rsp;
    logic                  rsp_valid;
    logic                  rsp_ready;

    mips_alu_pkg::ex_req_t req_q[$]; // Stimulus in file order
    mips_alu_pkg::ex_rsp_t exp_q[$]; // Expected, same order
    int                    error_count   = 0;
    int                    timeout_count = 0;
    int                    rsp_count     = 0;
    logic                  cases_ok      = 1'b0;
    logic                  stuck         = 1'b0;
    logic                  reset_checked = 1'b0;
    integer                seed          = 32'hf057;
    logic [31:0]           rnd;

    tb_clock_gen clock_i (.o_clk(clk), .o_arst_n(arst_n));

    mips_ex dut_i
    (
        .i_clk       (clk),
        .i_arst_n    (arst_n),
        .i_req       (req),
        .i_req_valid (req_valid),
        .o_req_ready (req_ready),
        .o_rsp       (rsp),
        .o_rsp_valid (rsp_valid),
        .i_rsp_ready (rsp_ready)
    );

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic check_result(input int idx, input mips_alu_pkg::ex_rsp_t got,
                                input mips_alu_pkg::ex_rsp_t exp);
        if (got.result !== exp.result)
        begin
            error_count++;
            $display("[ERROR] %0t ns: case %0d result %h, expected %h",
                     $time, idx, got.result, exp.result);
        end
        if (got.target !== exp.target)
        begin
            error_count++;
            $display("[ERROR] %0t ns: case %0d target %h, expected %h",
                     $time, idx, got.target, exp.target);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic load_cases();
        int                    fd;
        int                    n;
        string                 line;
        logic [31:0]           f_instr, f_pc, f_rs, f_rt, f_res;
        logic [31:0]           f_zero, f_taken, f_target, f_ill;
        mips_alu_pkg::ex_req_t c_req;
        mips_alu_pkg::ex_rsp_t c_exp;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the case file %s", CASE_FILE);
            return;
        end
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") // Column notes start with #
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_instr, f_pc, f_rs, f_rt,
                            f_res, f_zero, f_taken, f_target, f_ill);
                if (n == 9)
                begin
                    c_req.instr   = f_instr;
                    c_req.pc      = f_pc;
                    c_req.rs_val  = f_rs;
                    c_req.rt_val  = f_rt;
                    c_exp.result  = f_res;
                    c_exp.zero    = f_zero[0];
                    c_exp.taken   = f_taken[0];
                    c_exp.target  = f_target;
                    c_exp.illegal = f_ill[0];
                    req_q.push_back(c_req);
                    exp_q.push_back(c_exp);
                end
            end
        end
        $fclose(fd);
        cases_ok = (req_q.size() > 0);
        if (!cases_ok)
            $display("The case file %s holds no usable case", CASE_FILE);
    endtask

    // Called at edge + DRIVE_DELAY, returns at the same offset after the transfer
    task automatic send_request(input mips_alu_pkg::ex_req_t r);
        int waited;
        waited    = 0;
        req       = r;
        req_valid = 1'b1;
        @(negedge clk); // Ready settled here
        while (!req_ready && waited < WAIT_LIMIT)
        begin
            waited++;
            @(negedge clk);
        end
        if (!req_ready)
        begin
            $display("Request handshake stuck: o_req_ready low for %0d cycles", WAIT_LIMIT);
            timeout_count++;
            stuck = 1'b1;
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic finish_run();
        $display("Counts: %0d value errors, %0d timeouts, %0d assertion failures, %0d/%0d",
                 error_count, timeout_count, dut_i.sva_i.fail_count, rsp_count, exp_q.size());
        if (error_count == 0 && timeout_count == 0 && dut_i.sva_i.fail_count == 0 && cases_ok)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Random back-pressure
    //////////////////////////////////////////////////
    initial
    begin
        rsp_ready = 1'b0;
        forever
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            rnd       = $random(seed);
            rsp_ready = rnd[0]; // About half the cycles
        end
    end

    // Sampled at the falling edge, transfer follows on the next rising one
    always @(negedge clk)
    begin
        if (arst_n && !reset_checked)
        begin
            check_flag("o_rsp_valid after reset", rsp_valid, 1'b0);
            check_flag("o_req_ready after reset", req_ready, 1'b1);
            reset_checked <= 1'b1;
        end
        if (arst_n && rsp_valid && rsp_ready)
        begin
            if (rsp_count < exp_q.size())
            begin
                check_result(rsp_count, rsp, exp_q[rsp_count]);
                check_flag($sformatf("case %0d zero", rsp_count), rsp.zero,
                           exp_q[rsp_count].zero);
                check_flag($sformatf("case %0d taken", rsp_count), rsp.taken,
                           exp_q[rsp_count].taken);
                check_flag($sformatf("case %0d illegal", rsp_count), rsp.illegal,
                           exp_q[rsp_count].illegal);
            end
            else
            begin
                error_count++;
                $display("[ERROR] %0t ns: response %0d with no case left", $time, rsp_count);
            end
            rsp_count++;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial
    begin : stimulus
        int waited;
        req       = '0;
        req_valid = 1'b0;
        load_cases();
        waited = 0;
        while (arst_n !== 1'b1 && waited < WAIT_LIMIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b1)
        begin
            $display("Reset was still asserted after %0d cycles", WAIT_LIMIT);
            timeout_count++;
        end
        else if (cases_ok)
        begin
            #DRIVE_DELAY;
            foreach (req_q[k])
            begin
                if (!stuck)
                    send_request(req_q[k]);
            end
            req_valid = 1'b0;
            req       = '0;
            waited    = 0;
            while (!stuck && rsp_count < exp_q.size() && waited < WAIT_LIMIT)
            begin
                @(posedge clk);
                waited++;
            end
            if (!stuck && rsp_count < exp_q.size())
            begin
                $display("Response handshake stuck: only %0d of %0d responses taken",
                         rsp_count, exp_q.size());
                timeout_count++;
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* mips_ex.f */
logic/mips_isa_pkg.sv
logic/mips_alu_pkg.sv
logic/alu_control.sv
logic/alu.sv
logic/branch_unit.sv
logic/mips_ex.sv
testbench/tb_clock_gen.sv
testbench/mips_ex_sva.sv
testbench/mips_ex_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mips_ex_tb
FILELIST  = mips_ex.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the outcome"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/mips_ex_cases.txt */
# Hex columns: instr pc rs_val rt_val result zero taken target illegal
# R-type words carry rs=1 rt=2 rd=3, I-type words rs=1 rt=2
00221824 00000100 F0F0F0F0 FF00FF00 F000F000 0 0 00000000 0
00221825 00000104 F0F0F0F0 0F0F0F0F FFFFFFFF 0 0 00000000 0
00221820 00000108 FFFFFFFF 00000001 00000000 1 0 00000000 0
00221822 0000010C 00000000 00000001 FFFFFFFF 0 0 00000000 0
0022182B 00000110 00000001 FFFFFFFF 00000001 0 0 00000000 0
0022182B 00000114 FFFFFFFF 00000001 00000000 1 0 00000000 0
00221827 00000118 F0F0F0F0 0F0F0F00 0000000F 0 0 00000000 0
00221826 0000011C AAAAAAAA FFFF0000 5555AAAA 0 0 00000000 0
00221900 00000120 12345678 8000000F 000000F0 0 0 00000000 0
0022183F 00000124 00000001 00000002 FFFFFFFF 0 0 00000000 1
2022FFFF 00000200 00000010 00000000 0000000F 0 0 00000000 0
20228000 00000204 00008000 00000000 00000000 1 0 00000000 0
3022FFFF 00000208 12345678 00000000 00005678 0 0 00000000 0
34228001 0000020C FFFF0000 00000000 FFFF8001 0 0 00000000 0
3822FFFF 00000210 0000FFFF 00000000 00000000 1 0 00000000 0
2C22FFFF 00000214 FFFFFFFE 00000000 00000001 0 0 00000000 0
10220004 00001000 00000007 00000007 00000000 1 1 00001014 0
10220004 00001000 00000009 00000007 00000002 0 0 00001014 0
1422FFFC 00002000 00000003 00000008 FFFFFFFB 0 1 00001FF4 0
1422FFFF 00000000 ABCDEF01 ABCDEF01 00000000 1 0 00000000 0
FC220000 00000300 00000001 00000002 FFFFFFFF 0 0 00000000 1
08000010 00000304 00000001 00000002 FFFFFFFF 0 0 00000000 1
